// File: common/mips_defines.svh
/*
 * MIPS core widths, register count and reset fetch address
 */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// --------------------
// Datapath
// --------------------

// Machine word, also the address width
`define MIPS_XLEN 32

// --------------------
// Register file
// --------------------

`define MIPS_REG_ADDR_W 5
`define MIPS_NUM_REGS 32

// First fetch address out of reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// File: common/mips_pkg.sv
/*
 * MIPS core types
 * Word and register types, decode encodings and the stage payloads
 */
`include "mips_defines.svh"

package mips_pkg;

	typedef logic [`MIPS_XLEN-1:0] word_t;
	typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

	// Primary opcodes of the kept subset
	typedef enum logic [5:0] {
		OP_R_TYPE = 6'h00,
		OP_BEQ    = 6'h04,
		OP_ADDIU  = 6'h09,
		OP_LW     = 6'h23,
		OP_SW     = 6'h2b
	} opcode_e;

	// R-type function field
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_e;

	// ALU_ADD is zero so a bubble decodes as a harmless add
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_e;

	// Execute operand source
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_e;

	// --------------------
	// Stage payloads, all-zero is a bubble
	// --------------------

	typedef struct packed {
		word_t instr;
		word_t pc_plus4;
	} if_id_t;

	typedef struct packed {
		word_t     rs_value;
		word_t     rt_value;
		word_t     imm;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
		alu_op_e   alu_op;
		logic      use_imm;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		logic      branch;
		word_t     branch_target;
	} id_ex_t;

	typedef struct packed {
		word_t     alu_result;
		word_t     store_data;
		reg_addr_t dest;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
	} ex_mem_t;

	typedef struct packed {
		word_t     wb_value;
		reg_addr_t dest;
		logic      reg_write;
	} mem_wb_t;

endpackage

// File: logic/pipe_reg.sv
`timescale 1ns/1ps

/*
 * Pipeline stage register for any payload type
 */
module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     hold,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// Zero payload means bubble
	// Flush beats hold so a taken branch always squashes
	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
		// Hold keeps q as is
	end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

/*
 * Fetch stage program counter
 * Steps by four, holds on stall, redirects on a taken branch
 */
`include "mips_defines.svh"

module fetch_stage import mips_pkg::*; (
	input  logic  clock,
	input  logic  rst_n,
	input  logic  stall,
	input  logic  branch_taken,
	input  word_t branch_target,
	output word_t pc,
	output word_t pc_plus4
);

	// Sequential next address, also carried down to decode
	assign pc_plus4 = pc + word_t'(4);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc <= `MIPS_RESET_PC;
		end else if (branch_taken) begin
			// Redirect wins over a load-use stall
			pc <= branch_target;
		end else if (!stall) begin
			pc <= pc_plus4;
		end
	end

endmodule

// File: decode/reg_file.sv
`timescale 1ns/1ps

/*
 * General purpose register file
 * Two read ports, one write port, write-through to the readers
 */
`include "mips_defines.svh"

module reg_file import mips_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  reg_addr_t rs_addr,
	input  reg_addr_t rt_addr,
	output word_t     rs_value,
	output word_t     rt_value,
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	input  word_t     wr_value
);

	word_t regs [`MIPS_NUM_REGS];

	// Register zero reads zero, a same-cycle write is bypassed
	function automatic word_t read_port(input reg_addr_t addr);
		word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (wr_en && wr_addr == addr) begin
			value = wr_value;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		rs_value = read_port(rs_addr);
		rt_value = read_port(rt_addr);
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_value;
		end
	end

endmodule

// File: decode/decode_stage.sv
`timescale 1ns/1ps

/*
 * Decode stage
 * Field split, control decode, operand read and branch target
 */
module decode_stage import mips_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  if_id_t    if_id,
	input  logic      wb_en,
	input  reg_addr_t wb_addr,
	input  word_t     wb_value,
	output id_ex_t    id_ex,
	output reg_addr_t rs_addr,
	output reg_addr_t rt_addr
);

	opcode_e   opcode;
	funct_e    funct;
	reg_addr_t rd_addr;
	word_t     imm_ext;
	word_t     rs_value;
	word_t     rt_value;

	// --------------------
	// Instruction fields
	// --------------------
	assign opcode  = opcode_e'(if_id.instr[31:26]);
	assign rs_addr = if_id.instr[25:21];
	assign rt_addr = if_id.instr[20:16];
	assign rd_addr = if_id.instr[15:11];
	assign funct   = funct_e'(if_id.instr[5:0]);
	// Sign-extended 16-bit immediate
	assign imm_ext = {{16{if_id.instr[15]}}, if_id.instr[15:0]};

	// Writeback comes straight from MEM/WB
	reg_file u_reg_file (
		.clock    (clock),
		.rst_n    (rst_n),
		.rs_addr  (rs_addr),
		.rt_addr  (rt_addr),
		.rs_value (rs_value),
		.rt_value (rt_value),
		.wr_en    (wb_en),
		.wr_addr  (wb_addr),
		.wr_value (wb_value)
	);

	// --------------------
	// Control decode
	// --------------------
	always_comb begin
		// Start from a bubble, then fill in
		id_ex          = '0;
		id_ex.rs_value = rs_value;
		id_ex.rt_value = rt_value;
		id_ex.imm      = imm_ext;
		id_ex.rs       = rs_addr;
		id_ex.rt       = rt_addr;
		// PC plus 4 plus word offset
		id_ex.branch_target = if_id.pc_plus4 + {imm_ext[29:0], 2'b00};

		case (opcode)
			OP_R_TYPE: begin
				id_ex.dest      = rd_addr;
				id_ex.reg_write = 1'b1;
				case (funct)
					FN_ADDU: id_ex.alu_op = ALU_ADD;
					FN_SUBU: id_ex.alu_op = ALU_SUB;
					FN_AND:  id_ex.alu_op = ALU_AND;
					FN_OR:   id_ex.alu_op = ALU_OR;
					FN_SLT:  id_ex.alu_op = ALU_SLT;
					// Unknown funct, no write
					default: begin
						id_ex.dest      = '0;
						id_ex.reg_write = 1'b0;
					end
				endcase
			end
			OP_ADDIU: begin
				id_ex.dest      = rt_addr;
				id_ex.use_imm   = 1'b1;
				id_ex.reg_write = 1'b1;
			end
			OP_LW: begin
				// Address is rs plus offset
				id_ex.dest      = rt_addr;
				id_ex.use_imm   = 1'b1;
				id_ex.reg_write = 1'b1;
				id_ex.mem_read  = 1'b1;
			end
			OP_SW: begin
				id_ex.use_imm   = 1'b1;
				id_ex.mem_write = 1'b1;
			end
			OP_BEQ: begin
				id_ex.branch = 1'b1;
				id_ex.alu_op = ALU_SUB;
			end
			// Anything else stays a bubble
			default: ;
		endcase
	end

endmodule

// File: execute/exe_stage.sv
`timescale 1ns/1ps

/*
 * Execute stage
 * Forwarding muxes, ALU, BEQ compare and store data
 */
module exe_stage import mips_pkg::*; (
	input  id_ex_t   id_ex,
	input  fwd_sel_e fwd_a,
	input  fwd_sel_e fwd_b,
	input  word_t    mem_result,
	input  word_t    wb_result,
	output ex_mem_t  ex_mem,
	output logic     branch_taken,
	output word_t    branch_target
);

	word_t op_a;
	word_t rt_fwd;
	word_t op_b;
	word_t alu_result;

	// One operand source mux
	function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_value,
		input word_t mem_value, input word_t wb_value);
		word_t value;
		case (sel)
			FWD_MEM: value = mem_value;
			FWD_WB:  value = wb_value;
			default: value = reg_value;
		endcase
		return value;
	endfunction

	assign op_a   = fwd_mux(fwd_a, id_ex.rs_value, mem_result, wb_result);
	assign rt_fwd = fwd_mux(fwd_b, id_ex.rt_value, mem_result, wb_result);
	// Immediate replaces rt for ADDIU, LW and SW
	assign op_b   = id_ex.use_imm ? id_ex.imm : rt_fwd;

	// --------------------
	// ALU
	// --------------------
	always_comb begin
		case (id_ex.alu_op)
			ALU_SUB: alu_result = op_a - op_b;
			ALU_AND: alu_result = op_a & op_b;
			ALU_OR:  alu_result = op_a | op_b;
			// Signed compare, result 0 or 1
			ALU_SLT: alu_result = word_t'($signed(op_a) < $signed(op_b));
			default: alu_result = op_a + op_b;
		endcase
	end

	// BEQ compares the two forwarded registers, not op_b
	assign branch_taken  = id_ex.branch && (op_a == rt_fwd);
	assign branch_target = id_ex.branch_target;

	always_comb begin
		ex_mem.alu_result = alu_result;
		ex_mem.store_data = rt_fwd;
		ex_mem.dest       = id_ex.dest;
		ex_mem.reg_write  = id_ex.reg_write;
		ex_mem.mem_read   = id_ex.mem_read;
		ex_mem.mem_write  = id_ex.mem_write;
	end

endmodule

// File: execute/hazard_unit.sv
`timescale 1ns/1ps

/*
 * Hazard unit
 * Forward selects, load-use stall and branch flush
 */
module hazard_unit import mips_pkg::*; (
	input  reg_addr_t id_rs,
	input  reg_addr_t id_rt,
	input  reg_addr_t ex_rs,
	input  reg_addr_t ex_rt,
	input  reg_addr_t ex_dest,
	input  logic      ex_mem_read,
	input  reg_addr_t mem_dest,
	input  logic      mem_wr_en,
	input  reg_addr_t wb_dest,
	input  logic      wb_wr_en,
	input  logic      branch_taken,
	output fwd_sel_e  fwd_a,
	output fwd_sel_e  fwd_b,
	output logic      stall,
	output logic      flush_if_id,
	output logic      flush_id_ex
);

	logic load_use;

	// Youngest producer wins, register zero never forwards
	function automatic fwd_sel_e pick_source(input reg_addr_t src);
		fwd_sel_e sel;
		sel = FWD_REG;
		if (src != '0 && mem_wr_en && mem_dest == src) begin
			sel = FWD_MEM;
		end else if (src != '0 && wb_wr_en && wb_dest == src) begin
			sel = FWD_WB;
		end
		return sel;
	endfunction

	always_comb begin
		fwd_a = pick_source(ex_rs);
		fwd_b = pick_source(ex_rt);
	end

	// Load in execute feeding the instruction in decode
	assign load_use = ex_mem_read && (ex_dest != '0)
		&& (ex_dest == id_rs || ex_dest == id_rt);

	// Branch has priority over the stall
	assign stall       = load_use && !branch_taken;
	assign flush_if_id = branch_taken;
	// Bubble into execute on either event
	assign flush_id_ex = branch_taken || load_use;

endmodule

// File: logic/mips_core.sv
`timescale 1ns/1ps

/*
 * Five-stage MIPS I integer core
 * Stages, pipeline registers and hazard unit, memories outside
 */
module mips_core import mips_pkg::*; (
	input  logic  clock,
	input  logic  rst_n,
	output word_t instruction_addr,
	input  word_t instruction,
	output word_t data_addr,
	output word_t data_wr,
	output logic  mem_read,
	output logic  mem_write,
	input  word_t data_rd
);

	// --------------------
	// Stage wiring
	// --------------------
	word_t     pc;
	word_t     pc_plus4;
	if_id_t    if_id_d;
	if_id_t    if_id_q;
	id_ex_t    id_ex_d;
	id_ex_t    id_ex_q;
	ex_mem_t   ex_mem_d;
	ex_mem_t   ex_mem_q;
	mem_wb_t   mem_wb_d;
	mem_wb_t   mem_wb_q;
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	// Hazard controls
	fwd_sel_e  fwd_a;
	fwd_sel_e  fwd_b;
	logic      stall;
	logic      flush_if_id;
	logic      flush_id_ex;
	logic      branch_taken;
	word_t     branch_target;

	// --------------------
	// Fetch
	// --------------------
	fetch_stage u_fetch (
		.clock         (clock),
		.rst_n         (rst_n),
		.stall         (stall),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.pc            (pc),
		.pc_plus4      (pc_plus4)
	);

	assign instruction_addr = pc;
	assign if_id_d.instr    = instruction;
	assign if_id_d.pc_plus4 = pc_plus4;

	pipe_reg #(.payload_t(if_id_t)) u_if_id (
		.clock (clock), .rst_n (rst_n), .hold (stall), .flush (flush_if_id),
		.d (if_id_d), .q (if_id_q)
	);

	// --------------------
	// Decode, written back from MEM/WB
	// --------------------
	decode_stage u_decode (
		.clock    (clock),
		.rst_n    (rst_n),
		.if_id    (if_id_q),
		.wb_en    (mem_wb_q.reg_write),
		.wb_addr  (mem_wb_q.dest),
		.wb_value (mem_wb_q.wb_value),
		.id_ex    (id_ex_d),
		.rs_addr  (rs_addr),
		.rt_addr  (rt_addr)
	);

	// Stall turns this into a bubble via flush_id_ex
	pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clock (clock), .rst_n (rst_n), .hold (1'b0), .flush (flush_id_ex),
		.d (id_ex_d), .q (id_ex_q)
	);

	// --------------------
	// Execute
	// --------------------
	exe_stage u_exe (
		.id_ex         (id_ex_q),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.mem_result    (ex_mem_q.alu_result),
		.wb_result     (mem_wb_q.wb_value),
		.ex_mem        (ex_mem_d),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.clock (clock), .rst_n (rst_n), .hold (1'b0), .flush (1'b0),
		.d (ex_mem_d), .q (ex_mem_q)
	);

	// --------------------
	// Memory, data RAM sits outside
	// --------------------
	assign data_addr = ex_mem_q.alu_result;
	assign data_wr   = ex_mem_q.store_data;
	assign mem_read  = ex_mem_q.mem_read;
	assign mem_write = ex_mem_q.mem_write;

	// Load data or ALU result into writeback
	always_comb begin
		mem_wb_d.wb_value  = ex_mem_q.mem_read ? data_rd : ex_mem_q.alu_result;
		mem_wb_d.dest      = ex_mem_q.dest;
		mem_wb_d.reg_write = ex_mem_q.reg_write;
	end

	pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
		.clock (clock), .rst_n (rst_n), .hold (1'b0), .flush (1'b0),
		.d (mem_wb_d), .q (mem_wb_q)
	);

	// --------------------
	// Hazards
	// --------------------
	hazard_unit u_hazard (
		.id_rs        (rs_addr),
		.id_rt        (rt_addr),
		.ex_rs        (id_ex_q.rs),
		.ex_rt        (id_ex_q.rt),
		.ex_dest      (id_ex_q.dest),
		.ex_mem_read  (id_ex_q.mem_read),
		.mem_dest     (ex_mem_q.dest),
		.mem_wr_en    (ex_mem_q.reg_write),
		.wb_dest      (mem_wb_q.dest),
		.wb_wr_en     (mem_wb_q.reg_write),
		.branch_taken (branch_taken),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.stall        (stall),
		.flush_if_id  (flush_if_id),
		.flush_id_ex  (flush_id_ex)
	);

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

/*
 * Testbench clock and reset, 4 ns period, reset held 8 cycles
 */
module tb_clock_gen (
	output logic clock,
	output logic rst_n
);

	initial clock = 1'b0;

	always #2 clock = ~clock;

	// Reset low from time zero, released on a rising edge
	initial begin
		rst_n <= 1'b0;
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;
	end

endmodule

// File: verif/mips_chk.sv
`timescale 1ns/1ps

/*
 * Core protocol assertions, bound into mips_core
 */
module mips_chk import mips_pkg::*; (
	input logic  clock,
	input logic  rst_n,
	input word_t instruction_addr,
	input logic  mem_read,
	input logic  mem_write,
	input logic  stall
);

	// Load and store never share a memory cycle
	read_write_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write high in the same cycle");

	// Fetch stays on word boundaries
	fetch_aligned: assert property (@(posedge clock) disable iff (!rst_n)
		instruction_addr[1:0] == 2'b00)
		else $error("instruction_addr not word aligned");

	// Reset clears the memory stage strobes
	strobes_quiet_in_reset: assert property (@(posedge clock)
		!rst_n |=> (!mem_read && !mem_write))
		else $error("memory strobe high during reset");

	// Load-use stall freezes the PC for one cycle
	stall_holds_pc: assert property (@(posedge clock) disable iff (!rst_n)
		stall |=> $stable(instruction_addr))
		else $error("instruction_addr moved during a stall");

endmodule

bind mips_core mips_chk u_chk (
	.clock            (clock),
	.rst_n            (rst_n),
	.instruction_addr (instruction_addr),
	.mem_read         (mem_read),
	.mem_write        (mem_write),
	.stall            (stall)
);

// File: verif/tb_mips.sv
`timescale 1ns/1ps

/*
 * MIPS core testbench
 * ROM and RAM models, program and store tables, store checks
 */
`include "mips_defines.svh"

module tb_mips import mips_pkg::*; ();

	typedef struct packed {
		word_t addr;
		word_t data;
	} store_t;

	localparam int MEM_WORDS   = 64;
	localparam int EXTRA_WATCH = 24;

	logic   clock;
	logic   rst_n;
	word_t  instruction_addr;
	word_t  instruction;
	word_t  data_addr;
	word_t  data_wr;
	logic   mem_read;
	logic   mem_write;
	word_t  data_rd;

	word_t  rom [MEM_WORDS];
	word_t  ram [MEM_WORDS];
	word_t  ram_seed [8];
	// Architectural register values by the ISA rule
	word_t  gpr [16];
	word_t  program_words [$];
	store_t expected_stores [$];
	int     cycle_count = 0;
	int     timeout_cycles = 0;
	int     extra_stores;

	tb_clock_gen u_clock_gen (
		.clock (clock),
		.rst_n (rst_n)
	);

	mips_core u_dut (
		.clock            (clock),
		.rst_n            (rst_n),
		.instruction_addr (instruction_addr),
		.instruction      (instruction),
		.data_addr        (data_addr),
		.data_wr          (data_wr),
		.mem_read         (mem_read),
		.mem_write        (mem_write),
		.data_rd          (data_rd)
	);

	// --------------------
	// Memory models
	// --------------------
	// Combinational word-indexed reads
	assign instruction = rom[instruction_addr[7:2]];
	// Read data is only valid while the core asks for it
	assign data_rd     = mem_read ? ram[data_addr[7:2]] : 'x;

	always @(posedge clock) begin
		if (rst_n && mem_write) begin
			ram[data_addr[7:2]] <= data_wr;
		end
	end

	// --------------------
	// Encoding and ISA helpers
	// --------------------
	function automatic word_t sext16(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic word_t slt_value(input word_t a, input word_t b);
		return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
	endfunction

	function automatic word_t rtype_word(input funct_e fn, input int rd, input int rs,
		input int rt);
		return {OP_R_TYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic word_t itype_word(input opcode_e op, input int rt, input int rs,
		input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic void expect_store(input word_t addr, input word_t data);
		store_t entry;
		entry.addr = addr;
		entry.data = data;
		expected_stores.push_back(entry);
	endfunction

	function automatic void build_tables();
		// ALU chain with each result used by the next one
		program_words.push_back(itype_word(OP_ADDIU, 1, 0, 16'h1234));
		program_words.push_back(itype_word(OP_ADDIU, 2, 1, 16'hfffb));
		program_words.push_back(rtype_word(FN_ADDU, 3, 1, 2));
		program_words.push_back(rtype_word(FN_SUBU, 4, 3, 1));
		program_words.push_back(rtype_word(FN_AND, 5, 4, 3));
		program_words.push_back(rtype_word(FN_OR, 6, 5, 1));
		program_words.push_back(itype_word(OP_ADDIU, 9, 0, 16'h8001));
		program_words.push_back(rtype_word(FN_SLT, 7, 9, 4));
		program_words.push_back(rtype_word(FN_SLT, 8, 4, 9));
		program_words.push_back(itype_word(OP_SW, 3, 0, 16'h0040));
		program_words.push_back(itype_word(OP_SW, 4, 0, 16'h0044));
		program_words.push_back(itype_word(OP_SW, 5, 0, 16'h0048));
		program_words.push_back(itype_word(OP_SW, 6, 0, 16'h004c));
		program_words.push_back(itype_word(OP_SW, 7, 0, 16'h0050));
		program_words.push_back(itype_word(OP_SW, 8, 0, 16'h0054));
		program_words.push_back(itype_word(OP_SW, 9, 0, 16'h0058));
		// Store data taken straight from EX/MEM
		program_words.push_back(itype_word(OP_ADDIU, 10, 9, 16'h0010));
		program_words.push_back(itype_word(OP_SW, 10, 0, 16'h005c));
		// Load-use where the second load feeds the add directly
		program_words.push_back(itype_word(OP_LW, 11, 0, 16'h0000));
		program_words.push_back(itype_word(OP_LW, 12, 0, 16'h0004));
		program_words.push_back(rtype_word(FN_ADDU, 13, 11, 12));
		program_words.push_back(itype_word(OP_SW, 13, 0, 16'h0060));
		// Taken BEQ over two stores
		program_words.push_back(itype_word(OP_BEQ, 4, 2, 16'h0002));
		program_words.push_back(itype_word(OP_SW, 1, 0, 16'h0064));
		program_words.push_back(itype_word(OP_SW, 2, 0, 16'h0068));
		program_words.push_back(itype_word(OP_SW, 6, 0, 16'h006c));
		// Not-taken BEQ
		program_words.push_back(itype_word(OP_BEQ, 2, 1, 16'h0001));
		program_words.push_back(itype_word(OP_SW, 3, 0, 16'h0070));
		program_words.push_back(itype_word(OP_SW, 13, 0, 16'h0074));
		// Taken BEQ on a forwarded operand
		program_words.push_back(itype_word(OP_ADDIU, 14, 13, 16'h0000));
		program_words.push_back(itype_word(OP_BEQ, 13, 14, 16'h0001));
		program_words.push_back(itype_word(OP_SW, 1, 0, 16'h0078));
		program_words.push_back(itype_word(OP_SW, 14, 0, 16'h007c));
		// Park on a branch to itself
		program_words.push_back(itype_word(OP_BEQ, 0, 0, 16'hffff));

		gpr[1]  = sext16(16'h1234);
		gpr[2]  = gpr[1] + sext16(16'hfffb);
		gpr[3]  = gpr[1] + gpr[2];
		gpr[4]  = gpr[3] - gpr[1];
		gpr[5]  = gpr[4] & gpr[3];
		gpr[6]  = gpr[5] | gpr[1];
		gpr[9]  = sext16(16'h8001);
		gpr[7]  = slt_value(gpr[9], gpr[4]);
		gpr[8]  = slt_value(gpr[4], gpr[9]);
		gpr[10] = gpr[9] + sext16(16'h0010);
		gpr[11] = ram_seed[0];
		gpr[12] = ram_seed[1];
		gpr[13] = gpr[11] + gpr[12];
		gpr[14] = gpr[13] + sext16(16'h0000);

		expect_store(32'h40, gpr[3]);
		expect_store(32'h44, gpr[4]);
		expect_store(32'h48, gpr[5]);
		expect_store(32'h4c, gpr[6]);
		expect_store(32'h50, gpr[7]);
		expect_store(32'h54, gpr[8]);
		expect_store(32'h58, gpr[9]);
		expect_store(32'h5c, gpr[10]);
		expect_store(32'h60, gpr[13]);
		// Skipped stores only show up if the branch falls through
		if (gpr[2] != gpr[4]) begin
			expect_store(32'h64, gpr[1]);
			expect_store(32'h68, gpr[2]);
		end
		expect_store(32'h6c, gpr[6]);
		if (gpr[1] != gpr[2]) begin
			expect_store(32'h70, gpr[3]);
		end
		expect_store(32'h74, gpr[13]);
		if (gpr[14] != gpr[13]) begin
			expect_store(32'h78, gpr[1]);
		end
		expect_store(32'h7c, gpr[14]);
	endfunction

	// --------------------
	// Checks
	// --------------------
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_addr(input word_t actual, input word_t expected, input string name);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED at %0t: %s = 0x%08h, expected 0x%08h",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_data(input word_t actual, input word_t expected, input string name);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED at %0t: %s = 0x%08h, expected 0x%08h",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string name);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED at %0t: %s = %b, expected %b",
				$time, name, actual, expected));
		end
	endtask

	// Next falling edge with a store in the memory stage
	task automatic wait_for_store();
		do begin
			@(negedge clock);
		end while (mem_write !== 1'b1);
	endtask

	// Cycle budget scales with the program length
	always @(posedge clock) begin
		if (rst_n) begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= timeout_cycles) begin
				abort_run($sformatf("Timeout after %0d cycles with stores still missing",
					cycle_count));
			end
		end
	end

	initial begin
		void'($urandom(76));
		for (int i = 0; i < 8; i++) begin
			ram_seed[i] = $urandom();
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			if (i < 8) begin
				ram[i] <= ram_seed[i];
			end else begin
				ram[i] <= '0;
			end
			rom[i] = '0;
		end
		build_tables();
		foreach (program_words[i]) begin
			rom[i] = program_words[i];
		end
		timeout_cycles = program_words.size() * 4 + 40;

		// Fetch starts at the reset PC with both strobes low
		@(posedge rst_n);
		@(negedge clock);
		check_addr(instruction_addr, `MIPS_RESET_PC, "instruction_addr");
		check_flag(mem_read, 1'b0, "mem_read");
		check_flag(mem_write, 1'b0, "mem_write");

		// Every store against the next table entry
		foreach (expected_stores[i]) begin
			wait_for_store();
			check_addr(data_addr, expected_stores[i].addr, "data_addr");
			check_data(data_wr, expected_stores[i].data, "data_wr");
			check_flag(mem_read, 1'b0, "mem_read");
		end

		// Nothing past the end of the table
		extra_stores = 0;
		repeat (EXTRA_WATCH) begin
			@(negedge clock);
			if (mem_write) begin
				extra_stores++;
			end
		end
		if (extra_stores != 0) begin
			abort_run($sformatf("Found %0d store(s) beyond the expected table", extra_stores));
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

// File: mips.f
+incdir+common
common/mips_pkg.sv
logic/pipe_reg.sv
logic/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/exe_stage.sv
execute/hazard_unit.sv
logic/mips_core.sv
verif/tb_clock_gen.sv
verif/mips_chk.sv
verif/tb_mips.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips
FILELIST  ?= mips.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Regression failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
